/* include/alu_core_consts.svh */
// widths, opcodes and funct codes of the RV32 ALU core, included by the package and testbench
`ifndef ALU_CORE_CONSTS_SVH
`define ALU_CORE_CONSTS_SVH

// datapath and register index widths
`define XLEN            32
`define REG_IDX_BITS    5

// major opcodes kept by the core
`define OPC_OP          7'b0110011
`define OPC_OP_IMM      7'b0010011

// funct3 codes shared by R and I forms
`define F3_ADD_SUB      3'b000
`define F3_SLL          3'b001
`define F3_SLT          3'b010
`define F3_SLTU         3'b011
`define F3_XOR          3'b100
`define F3_SRL_SRA      3'b101
`define F3_OR           3'b110
`define F3_AND          3'b111

// funct7 that picks SUB over ADD and SRA over SRL
`define FUNCT7_ALT      7'b0100000

// full wfi encoding
`define INST_WFI        32'h10500073

`endif

/* hdl/alu_core_pkg.sv */
// shared instruction, ALU and pipeline packet types of the core, referenced by scoped name
`include "alu_core_consts.svh"

package alu_core_pkg;

    ////////////////////////////////
    // instruction formats
    ////////////////////////////////

    // register-register view
    typedef struct packed {
        logic [6:0]               funct7;
        logic [`REG_IDX_BITS-1:0] rs2;
        logic [`REG_IDX_BITS-1:0] rs1;
        logic [2:0]               funct3;
        logic [`REG_IDX_BITS-1:0] rd;
        logic [6:0]               opcode;
    } r_type_t;

    // register-immediate view
    typedef struct packed {
        logic [11:0]              imm;
        logic [`REG_IDX_BITS-1:0] rs1;
        logic [2:0]               funct3;
        logic [`REG_IDX_BITS-1:0] rd;
        logic [6:0]               opcode;
    } i_type_t;

    // one word decoded through either view
    typedef union packed {
        r_type_t r;
        i_type_t i;
    } inst_t;

    ////////////////////////////////
    // operation and status codes
    ////////////////////////////////

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_func_e;

    typedef enum logic [1:0] {
        NO_ERROR, ILLEGAL_INST, HALTED_ON_WFI
    } exception_e;

    ////////////////////////////////
    // stage packets
    ////////////////////////////////

    // decode to execute packet of 76 bits
    typedef struct packed {
        logic                     valid;
        alu_func_e                alu_func;
        logic [`XLEN-1:0]         opa;
        logic [`XLEN-1:0]         opb;
        logic [`REG_IDX_BITS-1:0] rd;
        exception_e               exception;
    } dec_packet_t;

    // execute to result and back to decode for bypass
    typedef struct packed {
        logic                     valid;
        logic [`REG_IDX_BITS-1:0] rd;
        logic [`XLEN-1:0]         value;
        exception_e               exception;
    } ex_result_t;

    // commit port seen outside the core
    typedef struct packed {
        logic                     valid;
        logic [`REG_IDX_BITS-1:0] rd;
        logic [`XLEN-1:0]         value;
    } commit_t;

endpackage

/* hdl/decode_stage.sv */
// takes instructions over the valid/ready handshake, decodes them and reads their operands
`include "alu_core_consts.svh"

module decode_stage (
    input  logic                      clock,
    input  logic                      reset,
    input  alu_core_pkg::inst_t       inst,
    input  logic                      inst_valid,
    input  alu_core_pkg::ex_result_t  ex_result,
    input  logic [`XLEN-1:0]          rs1_value,
    input  logic [`XLEN-1:0]          rs2_value,
    output logic                      inst_ready,
    output logic [`REG_IDX_BITS-1:0]  rs1_idx,
    output logic [`REG_IDX_BITS-1:0]  rs2_idx,
    output alu_core_pkg::dec_packet_t dec_packet
);

    alu_core_pkg::inst_t      inst_q;
    logic                     inst_valid_q;
    logic                     halt_q;
    logic                     halting;
    logic                     use_imm;
    logic [`XLEN-1:0]         imm_ext;
    alu_core_pkg::alu_func_e  alu_func;
    alu_core_pkg::exception_e exception;

    // funct3 plus the alt bit to an ALU op
    function automatic alu_core_pkg::alu_func_e map_func(input logic [2:0] funct3,
                                                         input logic alt);
        case (funct3)
            `F3_ADD_SUB: map_func = alt ? alu_core_pkg::ALU_SUB : alu_core_pkg::ALU_ADD;
            `F3_SLL:     map_func = alu_core_pkg::ALU_SLL;
            `F3_SLT:     map_func = alu_core_pkg::ALU_SLT;
            `F3_SLTU:    map_func = alu_core_pkg::ALU_SLTU;
            `F3_XOR:     map_func = alu_core_pkg::ALU_XOR;
            `F3_SRL_SRA: map_func = alt ? alu_core_pkg::ALU_SRA : alu_core_pkg::ALU_SRL;
            `F3_OR:      map_func = alu_core_pkg::ALU_OR;
            default:     map_func = alu_core_pkg::ALU_AND;
        endcase
    endfunction

    // forward from execute on an rd match or fall back to the register file
    function automatic logic [`XLEN-1:0] pick_operand(input logic [`REG_IDX_BITS-1:0] idx,
                                                      input logic [`XLEN-1:0] file_value);
        if (ex_result.valid && ex_result.rd != '0 && ex_result.rd == idx) begin
            pick_operand = ex_result.value;
        end else begin
            pick_operand = file_value;
        end
    endfunction

    ////////////////////////////////
    // instruction register
    ////////////////////////////////

    // word loaded on each accepted handshake
    always_ff @(posedge clock) begin
        if (inst_valid && inst_ready) begin
            inst_q <= inst;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            inst_valid_q <= 1'b0;
            halt_q       <= 1'b0;
        end else begin
            inst_valid_q <= inst_valid && inst_ready;
            // sticky until reset
            if (inst_valid_q && halting) begin
                halt_q <= 1'b1;
            end
        end
    end

    ////////////////////////////////
    // decode
    ////////////////////////////////

    always_comb begin
        alu_func  = alu_core_pkg::ALU_ADD;
        exception = alu_core_pkg::NO_ERROR;
        use_imm   = 1'b0;
        case (inst_q.r.opcode)
            `OPC_OP: begin
                alu_func = map_func(inst_q.r.funct3, inst_q.r.funct7 == `FUNCT7_ALT);
            end
            `OPC_OP_IMM: begin
                use_imm  = 1'b1;
                // upper imm bits act as funct7 only for SRAI
                alu_func = map_func(inst_q.i.funct3,
                                    inst_q.i.funct3 == `F3_SRL_SRA &&
                                    inst_q.r.funct7 == `FUNCT7_ALT);
            end
            default: begin
                exception = (inst_q == `INST_WFI) ? alu_core_pkg::HALTED_ON_WFI
                                                  : alu_core_pkg::ILLEGAL_INST;
            end
        endcase
    end

    assign halting = exception != alu_core_pkg::NO_ERROR;
    assign imm_ext = {{(`XLEN-12){inst_q.i.imm[11]}}, inst_q.i.imm};

    // rs2 field is a don't care for the I form
    assign rs1_idx = inst_q.r.rs1;
    assign rs2_idx = inst_q.r.rs2;

    // ready drops as soon as a halting word sits in decode
    assign inst_ready = !halt_q && !(inst_valid_q && halting);

    ////////////////////////////////
    // packet to execute
    ////////////////////////////////

    always_comb begin
        dec_packet.valid     = inst_valid_q;
        dec_packet.alu_func  = alu_func;
        dec_packet.opa       = pick_operand(rs1_idx, rs1_value);
        dec_packet.opb       = use_imm ? imm_ext : pick_operand(rs2_idx, rs2_value);
        dec_packet.rd        = halting ? '0 : inst_q.r.rd;
        dec_packet.exception = exception;
    end

endmodule

/* hdl/execute_stage.sv */
// registers the decoded packet and computes the integer ALU result
`include "alu_core_consts.svh"

module execute_stage (
    input  logic                      clock,
    input  logic                      reset,
    input  alu_core_pkg::dec_packet_t dec_packet,
    output alu_core_pkg::ex_result_t  ex_result
);

    alu_core_pkg::dec_packet_t dec_q;
    logic [`XLEN-1:0]          alu_out;
    logic [4:0]                shamt;

    ////////////////////////////////
    // decode to execute register
    ////////////////////////////////

    // no stall and a new packet every cycle
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            dec_q <= '0;
        end else begin
            dec_q <= dec_packet;
        end
    end

    ////////////////////////////////
    // ALU
    ////////////////////////////////

    // shift amount from low five bits of b
    assign shamt = dec_q.opb[4:0];

    always_comb begin
        case (dec_q.alu_func)
            alu_core_pkg::ALU_ADD: alu_out = dec_q.opa + dec_q.opb;
            alu_core_pkg::ALU_SUB: alu_out = dec_q.opa - dec_q.opb;
            alu_core_pkg::ALU_SLL: alu_out = dec_q.opa << shamt;
            alu_core_pkg::ALU_SLT: begin
                alu_out = {{(`XLEN-1){1'b0}}, $signed(dec_q.opa) < $signed(dec_q.opb)};
            end
            alu_core_pkg::ALU_SLTU: begin
                alu_out = {{(`XLEN-1){1'b0}}, dec_q.opa < dec_q.opb};
            end
            alu_core_pkg::ALU_XOR: alu_out = dec_q.opa ^ dec_q.opb;
            alu_core_pkg::ALU_SRL: alu_out = dec_q.opa >> shamt;
            // sign bit fills from the left
            alu_core_pkg::ALU_SRA: alu_out = $unsigned($signed(dec_q.opa) >>> shamt);
            alu_core_pkg::ALU_OR:  alu_out = dec_q.opa | dec_q.opb;
            alu_core_pkg::ALU_AND: alu_out = dec_q.opa & dec_q.opb;
            default:               alu_out = '0;
        endcase
    end

    ////////////////////////////////
    // result that is also the bypass source
    ////////////////////////////////

    always_comb begin
        ex_result.valid     = dec_q.valid;
        ex_result.rd        = dec_q.rd;
        // halting instructions carry value zero
        ex_result.value     = (dec_q.exception != alu_core_pkg::NO_ERROR) ? '0 : alu_out;
        ex_result.exception = dec_q.exception;
    end

endmodule

/* hdl/result_stage.sv */
// result stage holding the register file, the commit register and the latched error status
`include "alu_core_consts.svh"

module result_stage (
    input  logic                     clock,
    input  logic                     reset,
    input  alu_core_pkg::ex_result_t ex_result,
    input  logic [`REG_IDX_BITS-1:0] rs1_idx,
    input  logic [`REG_IDX_BITS-1:0] rs2_idx,
    output logic [`XLEN-1:0]         rs1_value,
    output logic [`XLEN-1:0]         rs2_value,
    output alu_core_pkg::commit_t    commit,
    output alu_core_pkg::exception_e error_status
);

    // x1..x31 only since x0 is hardwired
    logic [`XLEN-1:0] regs [1:31];
    logic             wr_en;

    ////////////////////////////////
    // register file
    ////////////////////////////////

    assign wr_en = ex_result.valid && ex_result.rd != '0;

    // same edge as commit, so a committed value is already readable
    always_ff @(posedge clock) begin
        if (wr_en) begin
            regs[ex_result.rd] <= ex_result.value;
        end
    end

    // asynchronous read ports for decode
    assign rs1_value = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_value = (rs2_idx == '0) ? '0 : regs[rs2_idx];

    ////////////////////////////////
    // commit register
    ////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            commit <= '0;
        end else begin
            commit.valid <= ex_result.valid;
            // payload only moves on a valid result
            if (ex_result.valid) begin
                commit.rd    <= ex_result.rd;
                commit.value <= ex_result.value;
            end
        end
    end

    ////////////////////////////////
    // error status
    ////////////////////////////////

    // first exception wins and holds until reset
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            error_status <= alu_core_pkg::NO_ERROR;
        end else if (error_status == alu_core_pkg::NO_ERROR && ex_result.valid) begin
            error_status <= ex_result.exception;
        end
    end

endmodule

/* hdl/alu_core.sv */
// top of the three-stage RV32 integer core chaining the decode, execute and result stages
`include "alu_core_consts.svh"

module alu_core (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     inst_valid,
    input  alu_core_pkg::inst_t      inst,
    output logic                     inst_ready,
    output alu_core_pkg::commit_t    commit,
    output alu_core_pkg::exception_e error_status
);

    // stage links
    alu_core_pkg::dec_packet_t dec_packet;
    alu_core_pkg::ex_result_t  ex_result;
    logic [`REG_IDX_BITS-1:0]  rs1_idx;
    logic [`REG_IDX_BITS-1:0]  rs2_idx;
    logic [`XLEN-1:0]          rs1_value;
    logic [`XLEN-1:0]          rs2_value;

    decode_stage u_decode_stage (
        .clock      (clock),
        .reset      (reset),
        .inst       (inst),
        .inst_valid (inst_valid),
        .ex_result  (ex_result),
        .rs1_value  (rs1_value),
        .rs2_value  (rs2_value),
        .inst_ready (inst_ready),
        .rs1_idx    (rs1_idx),
        .rs2_idx    (rs2_idx),
        .dec_packet (dec_packet)
    );

    execute_stage u_execute_stage (
        .clock      (clock),
        .reset      (reset),
        .dec_packet (dec_packet),
        .ex_result  (ex_result)
    );

    // owns the register file that decode reads
    result_stage u_result_stage (
        .clock        (clock),
        .reset        (reset),
        .ex_result    (ex_result),
        .rs1_idx      (rs1_idx),
        .rs2_idx      (rs2_idx),
        .rs1_value    (rs1_value),
        .rs2_value    (rs2_value),
        .commit       (commit),
        .error_status (error_status)
    );

endmodule

/* tb/alu_core_assertions.sv */
// concurrent checks on handshake, halt and commit rules, bound into every alu_core instance
module alu_core_assertions (
    input logic                     clock,
    input logic                     reset,
    input logic                     inst_ready,
    input alu_core_pkg::commit_t    commit,
    input alu_core_pkg::exception_e error_status
);

    // ready only returns through reset
    ready_stays_low: assert property (@(posedge clock) disable iff (reset)
        !inst_ready |=> !inst_ready)
        else $error("inst_ready rose again before reset");

    // first exception is held
    status_holds: assert property (@(posedge clock) disable iff (reset)
        (error_status != alu_core_pkg::NO_ERROR) |=> $stable(error_status))
        else $error("error_status changed before reset");

    // the halting commit is the last one
    no_commit_after_halt: assert property (@(posedge clock) disable iff (reset)
        (error_status != alu_core_pkg::NO_ERROR) |=> !commit.valid)
        else $error("commit after the halting instruction");

    commit_valid_known: assert property (@(posedge clock) disable iff (reset)
        !$isunknown(commit.valid))
        else $error("commit.valid is unknown");

endmodule

bind alu_core alu_core_assertions u_alu_core_assertions (
    .clock        (clock),
    .reset        (reset),
    .inst_ready   (inst_ready),
    .commit       (commit),
    .error_status (error_status)
);

/* tb/alu_core_tb.sv */
// directed testbench for alu_core: drives instructions, checks commits against a shadow model
`include "alu_core_consts.svh"

module alu_core_tb;

    localparam int RESET_CYCLES = 8;
    localparam int NUM_TESTS    = 6;
    // instructions issued or held over all tests with some margin
    localparam int INST_TOTAL   = 120;
    localparam int CYCLE_LIMIT  = INST_TOTAL + NUM_TESTS * (RESET_CYCLES + 10);

    // {alt, funct3} for add sub sll slt sltu xor srl sra or and
    localparam logic [3:0] R_OPS [0:9] = '{4'b0000, 4'b1000, 4'b0001, 4'b0010, 4'b0011,
                                           4'b0100, 4'b0101, 4'b1101, 4'b0110, 4'b0111};
    // addi slti sltiu xori ori andi slli srli srai
    localparam logic [3:0] I_OPS [0:8] = '{4'b0000, 4'b0010, 4'b0011, 4'b0100, 4'b0110,
                                           4'b0111, 4'b0001, 4'b0101, 4'b1101};

    logic                     clock;
    logic                     reset;
    logic                     inst_valid;
    alu_core_pkg::inst_t      inst;
    logic                     inst_ready;
    alu_core_pkg::commit_t    commit;
    alu_core_pkg::exception_e error_status;

    // shadow register file and expected commits in acceptance order
    logic [31:0]           shadow [0:31];
    alu_core_pkg::commit_t exp_q [$];
    int                    accept_q [$];
    int                    head;
    int                    cycle;
    int                    tests;
    int                    checks;
    int                    errors;
    int                    mon_checks;
    int                    mon_errors;

    alu_core u_alu_core (
        .clock        (clock),
        .reset        (reset),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .inst_ready   (inst_ready),
        .commit       (commit),
        .error_status (error_status)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // run-wide edge count that doubles as the watchdog
    always @(posedge clock) begin
        cycle <= cycle + 1;
        if (cycle == CYCLE_LIMIT) begin
            $display("timeout: run went past %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    ////////////////////////////////
    // reference model
    ////////////////////////////////

    // RV32 integer ops with shifts by b[4:0]
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            `F3_ADD_SUB: alu_ref = alt ? a - b : a + b;
            `F3_SLL:     alu_ref = a << sh;
            `F3_SLT: begin
                // differing signs make the negative one smaller
                if (a[31] != b[31]) begin
                    alu_ref = {31'd0, a[31]};
                end else begin
                    alu_ref = (a < b) ? 32'd1 : 32'd0;
                end
            end
            `F3_SLTU:    alu_ref = (a < b) ? 32'd1 : 32'd0;
            `F3_XOR:     alu_ref = a ^ b;
            `F3_SRL_SRA: begin
                if (alt) begin
                    // vacated top bits take the sign
                    alu_ref = (a >> sh) | (~(32'hffff_ffff >> sh) & {32{a[31]}});
                end else begin
                    alu_ref = a >> sh;
                end
            end
            `F3_OR:      alu_ref = a | b;
            default:     alu_ref = a & b;
        endcase
    endfunction

    function automatic alu_core_pkg::inst_t enc_r(input logic [6:0] funct7, input logic [4:0] rs2,
                                                  input logic [4:0] rs1, input logic [2:0] f3,
                                                  input logic [4:0] rd);
        alu_core_pkg::inst_t w;
        w.r.funct7 = funct7;
        w.r.rs2    = rs2;
        w.r.rs1    = rs1;
        w.r.funct3 = f3;
        w.r.rd     = rd;
        w.r.opcode = `OPC_OP;
        return w;
    endfunction

    function automatic alu_core_pkg::inst_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                                  input logic [2:0] f3, input logic [4:0] rd);
        alu_core_pkg::inst_t w;
        w.i.imm    = imm;
        w.i.rs1    = rs1;
        w.i.funct3 = f3;
        w.i.rd     = rd;
        w.i.opcode = `OPC_OP_IMM;
        return w;
    endfunction

    ////////////////////////////////
    // commit monitor
    ////////////////////////////////

    // each commit against the oldest expected entry
    always @(negedge clock) begin
        if (!reset && commit.valid === 1'b1) begin
            mon_checks = mon_checks + 3;
            if (head >= exp_q.size()) begin
                mon_errors++;
                $display("a commit of rd %0d came with no instruction outstanding", commit.rd);
            end else begin
                if (commit.rd !== exp_q[head].rd) begin
                    mon_errors++;
                    $display("** Error: commit.rd = %h, expected %h", commit.rd, exp_q[head].rd);
                end
                if (commit.value !== exp_q[head].value) begin
                    mon_errors++;
                    $display("** Error: commit.value = %h, expected %h",
                             commit.value, exp_q[head].value);
                end
                // fixed latency of two edges after accept
                if (cycle != accept_q[head] + 2) begin
                    mon_errors++;
                    $display("commit seen at edge %0d for an instruction accepted at edge %0d",
                             cycle, accept_q[head]);
                end
                head++;
            end
        end
    end

    ////////////////////////////////
    // drive helpers
    ////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error: %s = %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic do_reset();
        reset = 1'b1;
        inst_valid = 1'b0;
        repeat (RESET_CYCLES) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
    endtask

    // hold the word until accepted and log the expected commit
    task automatic send(input alu_core_pkg::inst_t word, input logic [4:0] rd,
                        input logic [31:0] value);
        alu_core_pkg::commit_t entry;
        entry.valid = 1'b1;
        entry.rd    = rd;
        entry.value = value;
        inst        = word;
        inst_valid  = 1'b1;
        while (inst_ready !== 1'b1) @(negedge clock);
        exp_q.push_back(entry);
        accept_q.push_back(cycle + 1);
        @(negedge clock);
    endtask

    task automatic op_r(input logic [3:0] op, input logic [4:0] rd, input logic [4:0] rs1,
                        input logic [4:0] rs2);
        logic [31:0] result;
        result = alu_ref(op[2:0], op[3], shadow[rs1], shadow[rs2]);
        send(enc_r(op[3] ? `FUNCT7_ALT : 7'b0, rs2, rs1, op[2:0], rd), rd, result);
        if (rd != '0) begin
            shadow[rd] = result;
        end
    endtask

    task automatic op_i(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                        input logic [11:0] imm);
        logic        alt;
        logic [31:0] result;
        // upper imm bits pick srai
        alt    = (f3 == `F3_SRL_SRA) && (imm[11:5] == `FUNCT7_ALT);
        result = alu_ref(f3, alt, shadow[rs1], {{20{imm[11]}}, imm});
        send(enc_i(imm, rs1, f3, rd), rd, result);
        if (rd != '0) begin
            shadow[rd] = result;
        end
    endtask

    // 10 + 11 + 11 bits through addi, slli and ori
    task automatic load_value(input logic [4:0] rd, input logic [31:0] value);
        op_i(`F3_ADD_SUB, rd, 5'd0, {2'b00, value[31:22]});
        op_i(`F3_SLL, rd, rd, 12'd11);
        op_i(`F3_OR, rd, rd, {1'b0, value[21:11]});
        op_i(`F3_SLL, rd, rd, 12'd11);
        op_i(`F3_OR, rd, rd, {1'b0, value[10:0]});
    endtask

    task automatic drain();
        inst_valid = 1'b0;
        while (head != exp_q.size()) @(negedge clock);
        // a few more edges to catch stray commits
        repeat (3) @(negedge clock);
    endtask

    task automatic hold_blocked(input alu_core_pkg::inst_t word);
        inst       = word;
        inst_valid = 1'b1;
        repeat (6) begin
            checks++;
            if (inst_ready !== 1'b0) begin
                errors++;
                $display("inst_ready was high while the core should be halted");
            end
            @(negedge clock);
        end
        inst_valid = 1'b0;
    endtask

    task automatic finish_test(input string name, input int start);
        int found;
        found = errors + mon_errors - start;
        tests++;
        if (found == 0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, found);
        end
    endtask

    ////////////////////////////////
    // tests
    ////////////////////////////////

    task automatic test_reset();
        int start;
        start = errors + mon_errors;
        do_reset();
        check_value("inst_ready", 32'(inst_ready), 32'd1);
        check_value("commit.valid", 32'(commit.valid), 32'd0);
        check_value("error_status", 32'(error_status), 32'(alu_core_pkg::NO_ERROR));
        finish_test("reset state", start);
    endtask

    task automatic test_reg_reg();
        int start;
        start = errors + mon_errors;
        do_reset();
        for (int r = 1; r <= 4; r++) begin
            load_value(5'(r), $urandom);
        end
        for (int round = 0; round < 2; round++) begin
            for (int k = 0; k < 10; k++) begin
                op_r(R_OPS[4'(k)], 5'(10 + k), 5'(1 + $urandom_range(3)),
                     5'(1 + $urandom_range(3)));
            end
        end
        drain();
        finish_test("register-register ALU", start);
    endtask

    task automatic test_reg_imm();
        int          start;
        logic [11:0] imm;
        logic [3:0]  op;
        start = errors + mon_errors;
        do_reset();
        // one negative source and one positive
        load_value(5'd1, $urandom | 32'h8000_0000);
        load_value(5'd2, $urandom & 32'h7fff_ffff);
        for (int round = 0; round < 2; round++) begin
            for (int k = 0; k < 9; k++) begin
                op  = I_OPS[4'(k)];
                imm = 12'($urandom);
                // negative immediates first round
                imm[11] = (round == 0);
                if (op[1:0] == 2'b01) begin
                    imm[11:5] = op[3] ? `FUNCT7_ALT : 7'b0;
                end
                op_i(op[2:0], 5'(10 + k), 5'(1 + round), imm);
            end
        end
        drain();
        finish_test("register-immediate ALU", start);
    endtask

    task automatic test_bypass();
        int         start;
        logic [4:0] rd;
        logic [4:0] prev;
        start = errors + mon_errors;
        do_reset();
        load_value(5'd1, $urandom);
        prev = 5'd1;
        // each op reads the rd just before it
        for (int k = 0; k < 12; k++) begin
            rd = 5'(2 + k % 5);
            op_r(R_OPS[4'($urandom_range(9))], rd, prev, 5'd1);
            prev = rd;
        end
        // x0 write is dropped and x0 reads zero
        op_i(`F3_ADD_SUB, 5'd0, prev, 12'h7ff);
        op_r(4'b0000, 5'd8, 5'd0, 5'd0);
        op_r(4'b0110, 5'd9, 5'd0, prev);
        drain();
        finish_test("back-to-back dependencies", start);
    endtask

    task automatic test_illegal();
        int                  start;
        alu_core_pkg::inst_t bad;
        start = errors + mon_errors;
        do_reset();
        load_value(5'd1, $urandom);
        op_r(4'b0000, 5'd2, 5'd1, 5'd1);
        bad          = $urandom;
        bad.r.opcode = 7'b1111111;
        send(bad, 5'd0, 32'd0);
        hold_blocked(enc_r(7'b0, 5'd1, 5'd1, `F3_ADD_SUB, 5'd3));
        drain();
        check_value("error_status", 32'(error_status), 32'(alu_core_pkg::ILLEGAL_INST));
        check_value("inst_ready", 32'(inst_ready), 32'd0);
        finish_test("illegal instruction", start);
    endtask

    task automatic test_wfi();
        int start;
        start = errors + mon_errors;
        do_reset();
        load_value(5'd1, $urandom);
        op_r(4'b0000, 5'd2, 5'd1, 5'd1);
        op_i(`F3_XOR, 5'd3, 5'd2, 12'($urandom));
        send(`INST_WFI, 5'd0, 32'd0);
        hold_blocked(enc_i(12'd1, 5'd3, `F3_ADD_SUB, 5'd4));
        drain();
        check_value("error_status", 32'(error_status), 32'(alu_core_pkg::HALTED_ON_WFI));
        check_value("inst_ready", 32'(inst_ready), 32'd0);
        finish_test("wfi halt", start);
    endtask

    initial begin
        reset      = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        void'($urandom(32'h51b4));
        for (int i = 0; i < 32; i++) begin
            shadow[5'(i)] = '0;
        end
        test_reset();
        test_reg_reg();
        test_reg_imm();
        test_bypass();
        test_illegal();
        test_wfi();
        $display("%0d tests, %0d checks, %0d errors", tests, checks + mon_checks,
                 errors + mon_errors);
        if (errors + mon_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+include
hdl/alu_core_pkg.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/result_stage.sv
hdl/alu_core.sv
tb/alu_core_assertions.sv
tb/alu_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the alu_core testbench with Verilator.
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -f sim.f --top-module alu_core_tb -o alu_core_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/alu_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Test passed$" sim.log; then
    exit 0
fi
exit 1
